// File: rtl/rv_core_pkg.sv
// shared sizes, encodings and pipeline packets for the rv_core RV32I subset
// referenced by scoped name from every RTL stage

package rv_core_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_DEPTH  = 1024;
    localparam int IMEM_ADDR_W = 10;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // operations the execute stage knows
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_NOP
    } alu_op_e;

    // --------------------------------------------------
    // pipeline packets
    // --------------------------------------------------

    // fetch -> decode, valid in the grant cycle
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_pkt_t;

    // decode -> execute, operands already resolved
    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       opa;
        logic [XLEN-1:0]       opb;
        logic                  wr_en;
        logic                  illegal;
    } exec_pkt_t;

    // execute -> register file and forwarding
    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_pkt_t;

endpackage

// File: rtl/inst_sram.sv
// single-port instruction memory with registered read and a req/gnt response
// a separate load port writes program words while the core is not running
`timescale 1ns/1ns

module inst_sram (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req,
    input  logic [rv_core_pkg::IMEM_ADDR_W-1:0] addr,
    output logic                               gnt,
    output logic [rv_core_pkg::XLEN-1:0]        rdata,
    input  logic                               load_en,
    input  logic [rv_core_pkg::IMEM_ADDR_W-1:0] load_addr,
    input  logic [rv_core_pkg::XLEN-1:0]        load_data
);

    logic [rv_core_pkg::XLEN-1:0] mem [rv_core_pkg::IMEM_DEPTH];

    // storage and read data
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (req) begin
            rdata <= mem[addr];
        end
    end

    // grant is the request delayed by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt <= 1'b0;
        end else begin
            gnt <= req;
        end
    end

endmodule

// File: rtl/instr_fetch.sv
// program counter and request logic toward the instruction memory
// stops issuing at halt_addr or when run drops; granted words go to decode
`timescale 1ns/1ns

module instr_fetch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               run,
    input  logic [rv_core_pkg::IMEM_ADDR_W-1:0] halt_addr,
    output logic                               imem_req,
    output logic [rv_core_pkg::IMEM_ADDR_W-1:0] imem_addr,
    input  logic                               imem_gnt,
    input  logic [rv_core_pkg::XLEN-1:0]        imem_rdata,
    output rv_core_pkg::fetch_pkt_t            fetch,
    output logic                               stopped
);

    localparam int PC_PAD = rv_core_pkg::XLEN - rv_core_pkg::IMEM_ADDR_W - 2;

    logic [rv_core_pkg::IMEM_ADDR_W-1:0] pc_q;
    logic [rv_core_pkg::IMEM_ADDR_W-1:0] gnt_idx;
    logic                                outstanding_q;
    logic                                can_issue;

    // --------------------------------------------------
    // request side
    // --------------------------------------------------
    assign can_issue = run && (pc_q != halt_addr);

    // one request in flight at most, a grant frees the slot the same cycle
    assign imem_req  = can_issue && (!outstanding_q || imem_gnt);
    assign imem_addr = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q          <= '0;
            outstanding_q <= 1'b0;
        end else begin
            if (imem_req) begin
                pc_q          <= pc_q + 1'b1;
                outstanding_q <= 1'b1;
            end else if (imem_gnt) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    // nothing more to issue and nothing in flight
    assign stopped = !can_issue && !outstanding_q;

    // --------------------------------------------------
    // response side
    // --------------------------------------------------

    // pc already moved past the granted word
    assign gnt_idx = pc_q - 1'b1;

    always_comb begin
        fetch.valid = imem_gnt;
        fetch.pc    = {{PC_PAD{1'b0}}, gnt_idx, 2'b00};
        fetch.instr = imem_rdata;
    end

endmodule

// File: rtl/instr_decode.sv
// decode stage: field split, operand read with forwarding, register file
// also serves the combinational debug read port of the register file
`timescale 1ns/1ns

module instr_decode (
    input  logic                              clk,
    input  logic                              rst_n,
    input  rv_core_pkg::fetch_pkt_t           fetch,
    input  rv_core_pkg::wb_pkt_t              wb,
    input  logic [rv_core_pkg::XLEN-1:0]       fwd_data,
    output rv_core_pkg::exec_pkt_t            exec,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] dbg_raddr,
    output logic [rv_core_pkg::XLEN-1:0]       dbg_rdata
);

    logic [rv_core_pkg::XLEN-1:0] regs [32];

    rv_core_pkg::opcode_e               opcode;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
    logic [2:0]                         funct3;
    logic [6:0]                         funct7;
    logic [rv_core_pkg::XLEN-1:0]       imm_i;
    logic [rv_core_pkg::XLEN-1:0]       rs1_val;
    logic [rv_core_pkg::XLEN-1:0]       rs2_val;
    rv_core_pkg::exec_pkt_t             exec_d;

    // --------------------------------------------------
    // field split
    // --------------------------------------------------
    assign opcode = rv_core_pkg::opcode_e'(fetch.instr[6:0]);
    assign rd     = fetch.instr[11:7];
    assign funct3 = fetch.instr[14:12];
    assign rs1    = fetch.instr[19:15];
    assign rs2    = fetch.instr[24:20];
    assign funct7 = fetch.instr[31:25];
    assign imm_i  = {{20{fetch.instr[31]}}, fetch.instr[31:20]};

    // operand source: x0, then execute result, then writeback, then array
    function automatic logic [rv_core_pkg::XLEN-1:0] read_operand(
        input logic [rv_core_pkg::REG_ADDR_W-1:0] rs,
        input logic [rv_core_pkg::XLEN-1:0]       rf_val,
        input rv_core_pkg::exec_pkt_t             ex,
        input logic [rv_core_pkg::XLEN-1:0]       ex_res,
        input rv_core_pkg::wb_pkt_t               wbp
    );
        logic [rv_core_pkg::XLEN-1:0] val;
        if (rs == '0) begin
            val = '0;
        end else if (ex.valid && ex.wr_en && (ex.rd == rs)) begin
            val = ex_res;
        end else if (wbp.wr_en && (wbp.rd == rs)) begin
            val = wbp.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rs1_val = read_operand(rs1, regs[rs1], exec, fwd_data, wb);
    assign rs2_val = read_operand(rs2, regs[rs2], exec, fwd_data, wb);

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb begin
        exec_d.valid   = fetch.valid;
        exec_d.alu_op  = rv_core_pkg::ALU_NOP;
        exec_d.rd      = rd;
        exec_d.opa     = rs1_val;
        exec_d.opb     = rs2_val;
        exec_d.wr_en   = 1'b0;
        exec_d.illegal = 1'b1;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    exec_d.alu_op  = rv_core_pkg::ALU_ADD;
                    exec_d.wr_en   = 1'b1;
                    exec_d.illegal = 1'b0;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    exec_d.alu_op  = rv_core_pkg::ALU_SUB;
                    exec_d.wr_en   = 1'b1;
                    exec_d.illegal = 1'b0;
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    exec_d.alu_op  = rv_core_pkg::ALU_ADD;
                    exec_d.opb     = imm_i;
                    exec_d.wr_en   = 1'b1;
                    exec_d.illegal = 1'b0;
                end
            end
            default: begin
                exec_d.illegal = 1'b1;
            end
        endcase
    end

    // stage register toward execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= exec_d.valid;
        end
        exec.alu_op  <= exec_d.alu_op;
        exec.rd      <= exec_d.rd;
        exec.opa     <= exec_d.opa;
        exec.opb     <= exec_d.opb;
        exec.wr_en   <= exec_d.wr_en;
        exec.illegal <= exec_d.illegal;
    end

    // --------------------------------------------------
    // register file
    // --------------------------------------------------

    // rd 0 never arrives with wr_en set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign dbg_rdata = regs[dbg_raddr];

endmodule

// File: rtl/alu_execute.sv
// execute and writeback stage: add or subtract, then register the result
// the combinational result also feeds decode forwarding
`timescale 1ns/1ns

module alu_execute (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rv_core_pkg::exec_pkt_t      exec,
    output logic [rv_core_pkg::XLEN-1:0] fwd_data,
    output rv_core_pkg::wb_pkt_t        wb,
    output logic                        retire,
    output logic                        illegal
);

    logic wr_ok;

    // --------------------------------------------------
    // alu
    // --------------------------------------------------
    always_comb begin
        case (exec.alu_op)
            rv_core_pkg::ALU_ADD: fwd_data = exec.opa + exec.opb;
            rv_core_pkg::ALU_SUB: fwd_data = exec.opa - exec.opb;
            default:              fwd_data = exec.opa;
        endcase
    end

    // writes to x0 are dropped here
    assign wr_ok = exec.valid && exec.wr_en && (exec.rd != '0);

    // --------------------------------------------------
    // writeback register and status pulses
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.wr_en <= 1'b0;
            retire   <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb.wr_en <= wr_ok;
            // every valid word retires, illegal ones as a no-op
            retire   <= exec.valid;
            illegal  <= exec.valid && exec.illegal;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd   <= exec.rd;
        wb.data <= fwd_data;
    end

endmodule

// File: rtl/rv_core_top.sv
// top of the rv_core: instruction memory, fetch, decode and execute
// programs go in through the load port, results come out through dbg_rdata
`timescale 1ns/1ns

module rv_core_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic [rv_core_pkg::IMEM_ADDR_W-1:0] halt_addr,
    input  logic                              load_en,
    input  logic [rv_core_pkg::IMEM_ADDR_W-1:0] load_addr,
    input  logic [rv_core_pkg::XLEN-1:0]       load_data,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] dbg_raddr,
    output logic [rv_core_pkg::XLEN-1:0]       dbg_rdata,
    output logic                              retire,
    output logic                              illegal,
    output logic                              idle
);

    logic                                imem_req;
    logic [rv_core_pkg::IMEM_ADDR_W-1:0] imem_addr;
    logic                                imem_gnt;
    logic [rv_core_pkg::XLEN-1:0]        imem_rdata;
    logic                                stopped;
    logic [rv_core_pkg::XLEN-1:0]        fwd_data;
    rv_core_pkg::fetch_pkt_t             fetch_pkt;
    rv_core_pkg::exec_pkt_t              exec_pkt;
    rv_core_pkg::wb_pkt_t                wb_pkt;

    inst_sram u_imem (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (imem_req),
        .addr     (imem_addr),
        .gnt      (imem_gnt),
        .rdata    (imem_rdata),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data)
    );

    instr_fetch u_if (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .halt_addr (halt_addr),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_gnt  (imem_gnt),
        .imem_rdata(imem_rdata),
        .fetch     (fetch_pkt),
        .stopped   (stopped)
    );

    instr_decode u_id (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch_pkt),
        .wb       (wb_pkt),
        .fwd_data (fwd_data),
        .exec     (exec_pkt),
        .dbg_raddr(dbg_raddr),
        .dbg_rdata(dbg_rdata)
    );

    alu_execute u_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .exec    (exec_pkt),
        .fwd_data(fwd_data),
        .wb      (wb_pkt),
        .retire  (retire),
        .illegal (illegal)
    );

    // idle once fetch is done and the pipeline has drained
    assign idle = stopped && !fetch_pkt.valid && !exec_pkt.valid && !retire;

endmodule

// File: testbench/rv_core_sva.sv
// concurrent checks on the fetch handshake and the x0 register
// bound into instr_fetch and instr_decode, one instance per stage
`timescale 1ns/1ns

module rv_core_sva #(
    // 1 for the fetch instance, 0 for the decode instance
    parameter bit WATCH_FETCH = 1'b1
) (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               req,
    input logic                               gnt,
    input logic [rv_core_pkg::IMEM_ADDR_W-1:0] addr,
    input logic [rv_core_pkg::IMEM_ADDR_W-1:0] halt_addr,
    input logic [rv_core_pkg::XLEN-1:0]        x0_val
);

    // number of failed assertions
    int unsigned fail_cnt = 0;

    if (WATCH_FETCH) begin : g_fetch
        // grant comes exactly one cycle after a request
        a_gnt_after_req: assert property (@(posedge clk) disable iff (!rst_n)
            req |=> gnt)
        else begin
            fail_cnt++;
            $error("grant missing one cycle after request");
        end

        a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
            gnt |-> $past(req))
        else begin
            fail_cnt++;
            $error("grant without a request in the previous cycle");
        end

        // the cycle after a request, a new one may only ride on its grant
        a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
            req |=> (!req || gnt))
        else begin
            fail_cnt++;
            $error("request issued while another is outstanding");
        end

        a_no_req_at_halt: assert property (@(posedge clk) disable iff (!rst_n)
            req |-> (addr != halt_addr))
        else begin
            fail_cnt++;
            $error("request issued at the halt address");
        end
    end else begin : g_decode
        a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
            x0_val == '0)
        else begin
            fail_cnt++;
            $error("register x0 is not zero");
        end
    end

endmodule

bind instr_fetch rv_core_sva #(.WATCH_FETCH(1'b1)) u_fetch_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (imem_req),
    .gnt      (imem_gnt),
    .addr     (imem_addr),
    .halt_addr(halt_addr),
    .x0_val   ('0)
);

// decode instance watches x0 only
bind instr_decode rv_core_sva #(.WATCH_FETCH(1'b0)) u_decode_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (1'b0),
    .gnt      (1'b0),
    .addr     ('0),
    .halt_addr('0),
    .x0_val   (regs[0])
);

// File: testbench/tb_rv_core.sv
// testbench for rv_core_top: loads small programs, runs them to idle and
// compares every register and the retire and illegal totals with a model
`timescale 1ns/1ns

module tb_rv_core;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int PAUSE_CYCLES  = 6;
    // reset, drain and register readout per program, in cycles
    localparam int PROG_OVERHEAD = 80;

    logic                               clk;
    logic                               rst_n;
    logic                               run;
    logic [rv_core_pkg::IMEM_ADDR_W-1:0] halt_addr;
    logic                               load_en;
    logic [rv_core_pkg::IMEM_ADDR_W-1:0] load_addr;
    logic [rv_core_pkg::XLEN-1:0]        load_data;
    logic [rv_core_pkg::REG_ADDR_W-1:0]  dbg_raddr;
    logic [rv_core_pkg::XLEN-1:0]        dbg_rdata;
    logic                               retire;
    logic                               illegal;
    logic                               idle;

    logic [31:0]                  lcg_state;
    logic [rv_core_pkg::XLEN-1:0] ref_regs [32];
    logic [31:0]                  cur_prog [$];
    logic [31:0]                  prog_dbl [$];
    logic [31:0]                  prog_fib [$];
    logic [31:0]                  prog_rnd [$];
    logic [31:0]                  prog_ill [$];
    logic [31:0]                  prog_pause [$];
    int                           dbl_n;
    int                           ill_inserted;
    int                           retire_cnt;
    int                           illegal_cnt;
    int                           error_cnt;
    int                           check_cnt;
    int                           sva_fails;
    bit                           built;

    rv_core_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .halt_addr(halt_addr),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .dbg_raddr(dbg_raddr),
        .dbg_rdata(dbg_rdata),
        .retire   (retire),
        .illegal  (illegal),
        .idle     (idle)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // retire and illegal pulse counters
    always @(posedge clk) begin
        if (rst_n) begin
            if (retire) retire_cnt++;
            if (illegal) illegal_cnt++;
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % n;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int unsigned kind;
        kind = rand_below(3);
        rd   = 5'(rand_below(32));
        rs1  = 5'(rand_below(32));
        rs2  = 5'(rand_below(32));
        imm  = 12'(rand_below(4096));
        if (kind == 0) return enc_r(7'b0000000, rd, rs1, rs2);
        if (kind == 1) return enc_r(7'b0100000, rd, rs1, rs2);
        return enc_addi(rd, rs1, imm);
    endfunction

    // load, branch, sll, slti and mul encodings
    function automatic logic [31:0] illegal_word();
        logic [4:0] rd;
        rd = 5'(rand_below(31) + 1);
        case (rand_below(5))
            0:       return {20'h00012, rd, 7'b0000011};
            1:       return {20'h00208, rd, 7'b1100011};
            2:       return {7'b0000000, 5'd2, 5'd1, 3'b001, rd, 7'b0110011};
            3:       return {12'h005, 5'd1, 3'b010, rd, 7'b0010011};
            default: return {7'b0000001, 5'd2, 5'd1, 3'b000, rd, 7'b0110011};
        endcase
    endfunction

    // reference model, returns 0 for words that are not ADD, SUB or ADDI
    function automatic bit ref_apply(input logic [31:0] w);
        logic [rv_core_pkg::XLEN-1:0] a;
        logic [rv_core_pkg::XLEN-1:0] b;
        logic [rv_core_pkg::XLEN-1:0] imm;
        logic [rv_core_pkg::XLEN-1:0] res;
        bit                           ok;
        a   = ref_regs[w[19:15]];
        b   = ref_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        res = '0;
        ok  = 1'b1;
        if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'b0000000) begin
            res = a + b;
        end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'b0100000) begin
            res = a - b;
        end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
            res = a + imm;
        end else begin
            ok = 1'b0;
        end
        if (ok && w[11:7] != 5'd0) ref_regs[w[11:7]] = res;
        return ok;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic check_reg(input string what, input int idx,
                             input logic [rv_core_pkg::XLEN-1:0] got,
                             input logic [rv_core_pkg::XLEN-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED at %0t ns: %s x%0d is %h, expected %h",
                     $time, what, idx, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            error_cnt++;
            $display("CHECK FAILED at %0t ns: %s count is %0d, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic build_programs();
        dbl_n = 1 + rand_below(31);
        prog_dbl.push_back(enc_addi(5'd1, 5'd0, 12'd1));
        repeat (dbl_n) prog_dbl.push_back(enc_r(7'b0000000, 5'd1, 5'd1, 5'd1));
        // fibonacci in x1, x2 with x3 as the new term
        prog_fib.push_back(enc_addi(5'd1, 5'd0, 12'd0));
        prog_fib.push_back(enc_addi(5'd2, 5'd0, 12'd1));
        repeat (1 + rand_below(40)) begin
            prog_fib.push_back(enc_r(7'b0000000, 5'd3, 5'd1, 5'd2));
            prog_fib.push_back(enc_addi(5'd1, 5'd2, 12'd0));
            prog_fib.push_back(enc_addi(5'd2, 5'd3, 12'd0));
        end
        prog_rnd.push_back(enc_addi(5'd7, 5'd0, 12'h800));
        prog_rnd.push_back(enc_addi(5'd0, 5'd7, 12'hfff));
        repeat (40) prog_rnd.push_back(rand_word());
        ill_inserted = 1;
        prog_ill.push_back(illegal_word());
        repeat (30) begin
            if (rand_below(4) == 0) begin
                prog_ill.push_back(illegal_word());
                ill_inserted++;
            end
            prog_ill.push_back(rand_word());
        end
        repeat (48) prog_pause.push_back(rand_word());
    endtask

    // reset, load cur_prog, run it to idle, then compare the register file
    task automatic run_program(input string name, input int pause_at, input int exp_illegal);
        int base_retire;
        int base_illegal;
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        rst_n = 1'b1;
        foreach (cur_prog[i]) begin
            load_en   = 1'b1;
            load_addr = rv_core_pkg::IMEM_ADDR_W'(i);
            load_data = cur_prog[i];
            next_cycle();
        end
        load_en = 1'b0;
        foreach (ref_regs[r]) ref_regs[r] = '0;
        foreach (cur_prog[i]) void'(ref_apply(cur_prog[i]));
        halt_addr    = rv_core_pkg::IMEM_ADDR_W'(cur_prog.size());
        base_retire  = retire_cnt;
        base_illegal = illegal_cnt;
        run          = 1'b1;
        if (pause_at > 0) begin
            repeat (pause_at) next_cycle();
            run = 1'b0;
            repeat (PAUSE_CYCLES) next_cycle();
            run = 1'b1;
        end
        do @(negedge clk); while (!idle);
        // idle means every word has already retired
        check_count({name, " retire at idle"}, retire_cnt - base_retire, cur_prog.size());
        next_cycle();
        run = 1'b0;
        for (int r = 0; r < 32; r++) begin
            dbg_raddr = rv_core_pkg::REG_ADDR_W'(r);
            @(negedge clk);
            check_reg(name, r, dbg_rdata, ref_regs[r]);
            next_cycle();
        end
        check_count({name, " retire"}, retire_cnt - base_retire, cur_prog.size());
        check_count({name, " illegal"}, illegal_cnt - base_illegal, exp_illegal);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        run         = 1'b0;
        halt_addr   = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        dbg_raddr   = '0;
        lcg_state   = 32'd80167;
        retire_cnt  = 0;
        illegal_cnt = 0;
        error_cnt   = 0;
        check_cnt   = 0;
        sva_fails   = 0;
        build_programs();
        built = 1'b1;
        next_cycle();
        cur_prog = prog_dbl;
        run_program("doubler", 0, 0);
        dbg_raddr = 5'd1;
        @(negedge clk);
        check_reg("doubler power of two", 1, dbg_rdata, 32'd1 << dbl_n);
        next_cycle();
        cur_prog = prog_fib;
        run_program("fibonacci", 0, 0);
        cur_prog = prog_rnd;
        run_program("random mix", 0, 0);
        cur_prog = prog_ill;
        run_program("illegal words", 0, ill_inserted);
        cur_prog = prog_pause;
        run_program("pause resume", 12, 0);
        sva_fails = dut.u_if.u_fetch_sva.fail_cnt + dut.u_id.u_decode_sva.fail_cnt;
        $display("%0d errors in %0d checks, %0d assertion failures",
                 error_cnt, check_cnt, sva_fails);
        if (error_cnt == 0 && sva_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        int  total_words;
        longint limit;
        wait (built);
        total_words = prog_dbl.size() + prog_fib.size() + prog_rnd.size()
                    + prog_ill.size() + prog_pause.size();
        // every word is loaded once and fetched once
        limit = (2 * total_words + 5 * PROG_OVERHEAD + PAUSE_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("ERROR: watchdog expired after %0d ns, a program never reached idle", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: rv_core.f
rtl/rv_core_pkg.sv
rtl/inst_sram.sv
rtl/instr_fetch.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/rv_core_top.sv
testbench/rv_core_sva.sv
testbench/tb_rv_core.sv
